//--- project.f
+incdir+bench
rtl/lbp_pkg.sv
rtl/lbp_history_table.sv
rtl/lbp_counter_table.sv
rtl/lbp_top.sv
bench/lbp_sva.sv
bench/tb_lbp.sv

//--- Bender.yml
package:
  name: lbp

sources:
  - files:
      - rtl/lbp_pkg.sv
      - rtl/lbp_history_table.sv
      - rtl/lbp_counter_table.sv
      - rtl/lbp_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lbp_sva.sv
      - bench/tb_lbp.sv

//--- bench/lbp_ref_model.svh
`ifndef LBP_REF_MODEL_SVH
`define LBP_REF_MODEL_SVH

// Reference state, one history and one counter entry per row and slot
lbp_pkg::history_t ref_hist  [lbp_pkg::LHR_ROWS][lbp_pkg::NR_SLOTS];
logic              ref_valid [lbp_pkg::CTR_ROWS][lbp_pkg::NR_SLOTS];
lbp_pkg::sat_ctr_t ref_ctr   [lbp_pkg::CTR_ROWS][lbp_pkg::NR_SLOTS];

// Reset leaves counters at 0, flush leaves them weakly taken
task automatic reset_tables(input logic flushed);
  for (int r = 0; r < lbp_pkg::LHR_ROWS; r++) begin
    for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
      ref_hist[r][s] = '0;
    end
  end
  for (int r = 0; r < lbp_pkg::CTR_ROWS; r++) begin
    for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
      ref_valid[r][s] = 1'b0;
      ref_ctr[r][s]   = flushed ? 2'b10 : 2'b00;
    end
  end
endtask

// Row is PC bits 5:2, every slot of the block reads its own history
function automatic lbp_pkg::slot_prediction_t expected_prediction(input lbp_pkg::vaddr_t pc);
  lbp_pkg::slot_prediction_t pred;
  lbp_pkg::history_t         h;
  for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
    h             = ref_hist[pc[5:2]][s];
    pred[s].valid = ref_valid[h][s];
    pred[s].taken = (ref_ctr[h][s] >= 2'd2);
  end
  return pred;
endfunction

// Index handed out at fetch is the history of slot 1
function automatic lbp_pkg::history_t expected_index(input lbp_pkg::vaddr_t pc);
  return ref_hist[pc[5:2]][1];
endfunction

// What a fetch queue would have kept for this branch
function automatic lbp_pkg::history_t saved_index(input lbp_pkg::vaddr_t pc);
  return ref_hist[pc[5:2]][pc[1]];
endfunction

// State change at one rising edge
task automatic apply_edge(input logic flush, input logic dbg,
                          input lbp_pkg::bht_update_t upd, input lbp_pkg::history_t idx);
  int unsigned row;
  int unsigned slot;
  row  = upd.pc[5:2];
  slot = upd.pc[1];
  if (flush) begin
    reset_tables(1'b1);
  end else if (upd.valid && !dbg) begin
    ref_hist[row][slot]  = {ref_hist[row][slot][2:0], upd.taken};
    ref_valid[idx][slot] = 1'b1;
    if (upd.taken && ref_ctr[idx][slot] != 2'd3) begin
      ref_ctr[idx][slot] = ref_ctr[idx][slot] + 2'd1;
    end else if (!upd.taken && ref_ctr[idx][slot] != 2'd0) begin
      ref_ctr[idx][slot] = ref_ctr[idx][slot] - 2'd1;
    end
  end
endtask

`endif

//--- bench/tb_lbp.sv
`timescale 1ns/100ps

module tb_lbp;

  localparam int unsigned CLK_HALF_NS    = 10;
  localparam int unsigned DRIVE_DELAY_NS = 2;
  localparam int unsigned CHECK_DELAY_NS = 16;
  localparam int unsigned RESET_CYCLES   = 3;

  // Cycles spent by each test
  localparam int unsigned RESET_TEST_CYCLES = 20;
  localparam int unsigned LEARN_CYCLES      = 9;
  localparam int unsigned MIX_CYCLES        = 60;
  localparam int unsigned DEBUG_CYCLES      = 30;
  localparam int unsigned FLUSH_CYCLES      = 3;
  localparam int unsigned RANDOM_CYCLES     = 200;
  localparam int unsigned TOTAL_CYCLES = RESET_CYCLES + RESET_TEST_CYCLES + LEARN_CYCLES +
                                         MIX_CYCLES + DEBUG_CYCLES + FLUSH_CYCLES +
                                         RANDOM_CYCLES;
  localparam int unsigned TIMEOUT_NS = TOTAL_CYCLES * 2 * CLK_HALF_NS + 500;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      flush_bp_i;
  logic                      debug_mode_i;
  lbp_pkg::vaddr_t           vpc_i;
  lbp_pkg::bht_update_t      bht_update_i;
  lbp_pkg::history_t         update_index_i;
  lbp_pkg::slot_prediction_t bht_prediction_o;
  lbp_pkg::history_t         index_o;

  integer          seed;
  int unsigned     err_cnt;
  int unsigned     pass_cnt;
  int unsigned     test_err_base;
  lbp_pkg::vaddr_t pc_pool [8];

  `include "lbp_ref_model.svh"

  lbp_top i_lbp_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_bp_i      (flush_bp_i),
    .debug_mode_i    (debug_mode_i),
    .vpc_i           (vpc_i),
    .bht_update_i    (bht_update_i),
    .update_index_i  (update_index_i),
    .bht_prediction_o(bht_prediction_o),
    .index_o         (index_o)
  );

  bind lbp_top lbp_sva i_lbp_sva (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_bp_i      (flush_bp_i),
    .debug_mode_i    (debug_mode_i),
    .vpc_i           (vpc_i),
    .bht_update_i    (bht_update_i),
    .bht_prediction_i(bht_prediction_o),
    .index_i         (index_o)
  );

  always #(CLK_HALF_NS) clk_i = ~clk_i;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
      err_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic lbp_pkg::bht_update_t make_update(input logic valid,
                                                       input lbp_pkg::vaddr_t pc,
                                                       input logic taken);
    lbp_pkg::bht_update_t upd;
    upd.valid = valid;
    upd.pc    = pc;
    upd.taken = taken;
    return upd;
  endfunction

  // Called 2 ns after an edge and returns 2 ns after the next one
  task automatic run_cycle(input lbp_pkg::vaddr_t pc, input lbp_pkg::bht_update_t upd,
                           input lbp_pkg::history_t idx, input logic dbg, input logic flush);
    vpc_i          = pc;
    bht_update_i   = upd;
    update_index_i = idx;
    debug_mode_i   = dbg;
    flush_bp_i     = flush;
    #(CHECK_DELAY_NS);
    compare_value("bht_prediction_o", expected_prediction(pc), bht_prediction_o);
    compare_value("index_o", expected_index(pc), index_o);
    @(posedge clk_i);
    apply_edge(flush, dbg, upd, idx);
    #(DRIVE_DELAY_NS);
  endtask

  task automatic random_traffic(input int unsigned n, input int unsigned nr_pcs,
                                input logic dbg, input logic hold_vpc,
                                input int unsigned taken_pct);
    lbp_pkg::vaddr_t   upd_pc;
    lbp_pkg::vaddr_t   look_pc;
    lbp_pkg::history_t idx;
    logic              valid;
    logic              taken;
    for (int unsigned i = 0; i < n; i++) begin
      upd_pc = pc_pool[rand_below(nr_pcs)];
      valid  = (rand_below(4) != 0);
      taken  = (rand_below(100) < taken_pct);
      // Mostly the index saved at fetch with a stale one now and then
      if (rand_below(4) != 0) begin
        idx = saved_index(upd_pc);
      end else begin
        idx = lbp_pkg::history_t'(rand_below(16));
      end
      look_pc = hold_vpc ? pc_pool[0] : pc_pool[rand_below(nr_pcs)];
      run_cycle(look_pc, make_update(valid, upd_pc, taken), idx, dbg, 1'b0);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %-16s done, %0d errors", name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  initial begin
    lbp_pkg::vaddr_t           learn_pc;
    lbp_pkg::history_t         snap_index;
    lbp_pkg::slot_prediction_t snap_pred;

    seed          = 32'hec1aeb7e;
    err_cnt       = 0;
    pass_cnt      = 0;
    test_err_base = 0;
    // Rows 4 and 9 are shared on purpose and one PC has bit 0 set
    pc_pool[0] = 32'h0000_0010;
    pc_pool[1] = 32'h0000_0012;
    pc_pool[2] = 32'h0000_0410;
    pc_pool[3] = 32'h0000_0017;
    pc_pool[4] = 32'h8000_0052;
    pc_pool[5] = 32'h0000_0024;
    pc_pool[6] = 32'h0000_1026;
    pc_pool[7] = 32'h0000_003c;

    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    flush_bp_i     = 1'b0;
    debug_mode_i   = 1'b0;
    vpc_i          = '0;
    bht_update_i   = '0;
    update_index_i = '0;
    reset_tables(1'b0);

    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY_NS);
    rst_ni = 1'b1;

    for (int i = 0; i < RESET_TEST_CYCLES; i++) begin
      run_cycle(pc_pool[rand_below(8)], make_update(1'b0, pc_pool[rand_below(8)], 1'b1),
                lbp_pkg::history_t'(rand_below(16)), 1'b0, 1'b0);
    end
    finish_test("reset_state");

    // Learning PC sits in slot 1 of row 5
    learn_pc = 32'h0000_1a16;
    for (int i = 0; i < LEARN_CYCLES - 1; i++) begin
      run_cycle(learn_pc, make_update(1'b1, learn_pc, 1'b1), saved_index(learn_pc),
                1'b0, 1'b0);
    end
    run_cycle(learn_pc, make_update(1'b0, '0, 1'b0), '0, 1'b0, 1'b0);
    compare_value("bht_prediction_o[1]", 2'b11, bht_prediction_o[1]);
    finish_test("learning");

    // Strongly biased halves drive counters into both limits
    random_traffic(MIX_CYCLES / 2, 3, 1'b0, 1'b0, 85);
    random_traffic(MIX_CYCLES / 2, 3, 1'b0, 1'b0, 15);
    finish_test("saturation");

    snap_index = expected_index(pc_pool[0]);
    snap_pred  = expected_prediction(pc_pool[0]);
    random_traffic(DEBUG_CYCLES, 8, 1'b1, 1'b1, 50);
    compare_value("index_o", snap_index, index_o);
    compare_value("bht_prediction_o", snap_pred, bht_prediction_o);
    finish_test("debug_suppress");

    // Update in the flush cycle must lose
    run_cycle(pc_pool[1], make_update(1'b1, pc_pool[1], 1'b1), saved_index(pc_pool[1]),
              1'b0, 1'b1);
    compare_value("index_o", 32'h0, index_o);
    compare_value("bht_prediction_o.valid", 2'b00,
                  {bht_prediction_o[1].valid, bht_prediction_o[0].valid});
    run_cycle(pc_pool[2], make_update(1'b1, pc_pool[2], 1'b0), saved_index(pc_pool[2]),
              1'b0, 1'b0);
    // Weakly taken minus one gives valid and not taken
    compare_value("bht_prediction_o[0]", 2'b10, bht_prediction_o[0]);
    run_cycle(pc_pool[2], make_update(1'b0, '0, 1'b0), '0, 1'b0, 1'b0);
    finish_test("flush");

    random_traffic(RANDOM_CYCLES, 8, 1'b0, 1'b0, 50);
    finish_test("slot_independence");

    $display("Checks passed %0d, errors %0d, assertion failures %0d",
             pass_cnt, err_cnt, i_lbp_top.i_lbp_sva.assert_fail_cnt);
    if (err_cnt == 0 && i_lbp_top.i_lbp_sva.assert_fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns before all tests completed", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

endmodule

//--- bench/lbp_sva.sv
`timescale 1ns/100ps

module lbp_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      flush_bp_i,
  input logic                      debug_mode_i,
  input lbp_pkg::vaddr_t           vpc_i,
  input lbp_pkg::bht_update_t      bht_update_i,
  input lbp_pkg::slot_prediction_t bht_prediction_i,
  input lbp_pkg::history_t         index_i
);

  // Read by the testbench at the end of the run
  int unsigned assert_fail_cnt = 0;

  logic any_valid;

  always_comb begin
    any_valid = 1'b0;
    for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
      any_valid = any_valid | bht_prediction_i[s].valid;
    end
  end

  // --------------------------------------------------
  // Flush, debug and reset behavior
  // --------------------------------------------------

  a_flush_invalidates : assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_bp_i |=> !any_valid)
  else begin
    assert_fail_cnt++;
    $error("A prediction is valid in the cycle after a flush");
  end

  // Same fetch PC one cycle later must see the same state
  a_debug_holds_state : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (debug_mode_i && bht_update_i.valid && !flush_bp_i) |=>
      (!$stable(vpc_i) || ($stable(index_i) && $stable(bht_prediction_i))))
  else begin
    assert_fail_cnt++;
    $error("An update in debug mode changed the predictor state");
  end

  a_index_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(index_i))
  else begin
    assert_fail_cnt++;
    $error("index_o is unknown after reset");
  end

endmodule

//--- rtl/lbp_top.sv
`timescale 1ns/100ps

module lbp_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_bp_i,
  input  logic                      debug_mode_i,
  // Fetch PC
  input  lbp_pkg::vaddr_t           vpc_i,
  // Resolved branch
  input  lbp_pkg::bht_update_t      bht_update_i,
  // History saved from index_o when the branch was fetched
  input  lbp_pkg::history_t         update_index_i,
  output lbp_pkg::slot_prediction_t bht_prediction_o,
  // History to keep with the fetch block for its later update
  output lbp_pkg::history_t         index_o
);

  lbp_pkg::slot_history_t lookup_hist;

  // --------------------------------------------------
  // First level, local histories
  // --------------------------------------------------

  lbp_history_table i_history_table (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_bp_i   (flush_bp_i),
    .debug_mode_i (debug_mode_i),
    .vpc_i        (vpc_i),
    .bht_update_i (bht_update_i),
    .lookup_hist_o(lookup_hist)
  );

  // --------------------------------------------------
  // Second level, pattern counters
  // --------------------------------------------------

  lbp_counter_table i_counter_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_bp_i    (flush_bp_i),
    .debug_mode_i  (debug_mode_i),
    .lookup_hist_i (lookup_hist),
    .bht_update_i  (bht_update_i),
    .update_index_i(update_index_i),
    .prediction_o  (bht_prediction_o)
  );

  // Last slot's history is the one handed back for the update
  assign index_o = lookup_hist[lbp_pkg::NR_SLOTS-1];

endmodule

//--- rtl/lbp_counter_table.sv
`timescale 1ns/100ps

module lbp_counter_table (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_bp_i,
  input  logic                      debug_mode_i,
  input  lbp_pkg::slot_history_t    lookup_hist_i,
  input  lbp_pkg::bht_update_t      bht_update_i,
  input  lbp_pkg::history_t         update_index_i,
  output lbp_pkg::slot_prediction_t prediction_o
);

  // Pattern table entry
  typedef struct packed {
    logic              valid;
    lbp_pkg::sat_ctr_t ctr;
  } ctr_entry_t;

  ctr_entry_t ctr_q [lbp_pkg::CTR_ROWS-1:0][lbp_pkg::NR_SLOTS-1:0];

  lbp_pkg::slot_t    update_slot;
  lbp_pkg::sat_ctr_t ctr_cur;
  lbp_pkg::sat_ctr_t ctr_next;
  logic              update_en;

  // --------------------------------------------------
  // Prediction
  // --------------------------------------------------

  // Each slot looks up its own pattern row through its own history
  for (genvar i = 0; i < lbp_pkg::NR_SLOTS; i++) begin : gen_predict
    ctr_entry_t entry;

    assign entry = ctr_q[lookup_hist_i[i]][i];

    assign prediction_o[i].valid = entry.valid;
    // Upper half of the counter range means taken
    assign prediction_o[i].taken = entry.ctr[lbp_pkg::CTR_BITS-1];
  end

  // --------------------------------------------------
  // Saturating update
  // --------------------------------------------------

  assign update_slot = lbp_pkg::pc_slot(bht_update_i.pc);
  assign update_en   = bht_update_i.valid && !debug_mode_i;

  // Row comes from the history saved at fetch, not from the current table
  assign ctr_cur = ctr_q[update_index_i][update_slot].ctr;

  always_comb begin
    ctr_next = ctr_cur;
    if (bht_update_i.taken) begin
      if (ctr_cur != lbp_pkg::CTR_MAX_VAL) begin
        ctr_next = ctr_cur + 1'b1;
      end
    end else begin
      if (ctr_cur != '0) begin
        ctr_next = ctr_cur - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < lbp_pkg::CTR_ROWS; r++) begin
        for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
          ctr_q[r][s] <= '0;
        end
      end
    end else if (flush_bp_i) begin
      // Evict everything, restart from weakly taken
      for (int r = 0; r < lbp_pkg::CTR_ROWS; r++) begin
        for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
          ctr_q[r][s].valid <= 1'b0;
          ctr_q[r][s].ctr   <= lbp_pkg::CTR_FLUSH_VAL;
        end
      end
    end else if (update_en) begin
      ctr_q[update_index_i][update_slot].valid <= 1'b1;
      ctr_q[update_index_i][update_slot].ctr   <= ctr_next;
    end
  end

endmodule

//--- rtl/lbp_history_table.sv
`timescale 1ns/100ps

module lbp_history_table (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_bp_i,
  input  logic                   debug_mode_i,
  input  lbp_pkg::vaddr_t        vpc_i,
  input  lbp_pkg::bht_update_t   bht_update_i,
  output lbp_pkg::slot_history_t lookup_hist_o
);

  // One local history per row and slot
  lbp_pkg::history_t lhr_q [lbp_pkg::LHR_ROWS-1:0][lbp_pkg::NR_SLOTS-1:0];

  lbp_pkg::lhr_row_t lookup_row;
  lbp_pkg::lhr_row_t update_row;
  lbp_pkg::slot_t    update_slot;
  lbp_pkg::history_t update_hist_cur;
  lbp_pkg::history_t update_hist_next;
  logic              update_en;

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  assign lookup_row = lbp_pkg::pc_row(vpc_i);

  // All slots of the fetch block share the row
  for (genvar i = 0; i < lbp_pkg::NR_SLOTS; i++) begin : gen_lookup
    assign lookup_hist_o[i] = lhr_q[lookup_row][i];
  end

  // --------------------------------------------------
  // Update
  // --------------------------------------------------

  assign update_row  = lbp_pkg::pc_row(bht_update_i.pc);
  assign update_slot = lbp_pkg::pc_slot(bht_update_i.pc);

  // Resolved branches are ignored while the core is halted in debug
  assign update_en = bht_update_i.valid && !debug_mode_i;

  assign update_hist_cur = lhr_q[update_row][update_slot];

  // Oldest outcome drops off the top, newest enters at bit 0
  assign update_hist_next = {update_hist_cur[lbp_pkg::HIST_BITS-2:0], bht_update_i.taken};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < lbp_pkg::LHR_ROWS; r++) begin
        for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
          lhr_q[r][s] <= '0;
        end
      end
    end else if (flush_bp_i) begin
      // Flush wins over an update in the same cycle
      for (int r = 0; r < lbp_pkg::LHR_ROWS; r++) begin
        for (int s = 0; s < lbp_pkg::NR_SLOTS; s++) begin
          lhr_q[r][s] <= '0;
        end
      end
    end else if (update_en) begin
      lhr_q[update_row][update_slot] <= update_hist_next;
    end
  end

endmodule

//--- rtl/lbp_pkg.sv
package lbp_pkg;

  // --------------------------------------------------
  // Table shape
  // --------------------------------------------------

  // Instructions per fetch block
  localparam int unsigned NR_SLOTS  = 2;
  // Compressed instructions, so PC bit 0 carries no information
  localparam int unsigned PC_OFFSET = 1;
  // PC bits that pick the slot inside a fetch block
  localparam int unsigned SLOT_BITS = 1;

  // Local history table
  localparam int unsigned LHR_ROWS  = 16;
  localparam int unsigned ROW_BITS  = $clog2(LHR_ROWS);
  localparam int unsigned HIST_BITS = 4;

  // Pattern table, one row per history value
  localparam int unsigned CTR_ROWS  = 16;
  localparam int unsigned CTR_BITS  = 2;

  localparam int unsigned VLEN = 32;

  // --------------------------------------------------
  // Width types
  // --------------------------------------------------

  typedef logic [VLEN-1:0]      vaddr_t;
  typedef logic [SLOT_BITS-1:0] slot_t;
  typedef logic [ROW_BITS-1:0]  lhr_row_t;
  typedef logic [HIST_BITS-1:0] history_t;
  typedef logic [CTR_BITS-1:0]  sat_ctr_t;

  // Counter bounds and the weakly taken value loaded by a flush
  localparam sat_ctr_t CTR_MAX_VAL   = sat_ctr_t'((1 << CTR_BITS) - 1);
  localparam sat_ctr_t CTR_FLUSH_VAL = 2'b10;

  // --------------------------------------------------
  // Update and prediction records
  // --------------------------------------------------

  // Resolved branch from execute
  typedef struct packed {
    logic   valid;
    vaddr_t pc;
    logic   taken;
  } bht_update_t;

  typedef struct packed {
    logic valid;
    logic taken;
  } bht_prediction_t;

  typedef history_t        [NR_SLOTS-1:0] slot_history_t;
  typedef bht_prediction_t [NR_SLOTS-1:0] slot_prediction_t;

  // --------------------------------------------------
  // PC decoding shared by both tables
  // --------------------------------------------------

  // Slot number, PC bit 1
  function automatic slot_t pc_slot(vaddr_t pc);
    return pc[PC_OFFSET +: SLOT_BITS];
  endfunction

  // History row, PC bits 5:2
  function automatic lhr_row_t pc_row(vaddr_t pc);
    return pc[PC_OFFSET + SLOT_BITS +: ROW_BITS];
  endfunction

endpackage
